// File: hw/term_params.svh
// fixed 24x80 geometry on an 11-bit circular buffer; control codes are 7-bit ASCII
`ifndef TERM_PARAMS_SVH
`define TERM_PARAMS_SVH

// screen geometry
`define TERM_ROWS 24
`define TERM_COLS 80
`define TERM_BUF_SIZE 1920
// address of the last row, (rows - 1) * cols
`define TERM_LAST_ROW 1840

// field widths
`define TERM_ADDR_BITS 11
`define TERM_ROW_BITS 5
`define TERM_COL_BITS 7

// tab jumps to the next multiple of 8 below this column
`define TERM_TAB_LIMIT 71

// control byte codes
`define TERM_CH_BS 8'h08
`define TERM_CH_TAB 8'h09
`define TERM_CH_LF 8'h0A
`define TERM_CH_CR 8'h0D
`define TERM_CH_ESC 8'h1B
`define TERM_CH_DEL 8'h7F
`define TERM_CH_SPACE 8'h20
// bias on the Esc-Y row and column bytes
`define TERM_POS_OFFSET 8'h20

`endif

// File: hw/term_pkg.sv
// types for the terminal; widths follow term_params.svh and are not meant to be changed alone
`include "term_params.svh"

package term_pkg;

   typedef logic [7:0] char_t;
   typedef logic [`TERM_ADDR_BITS-1:0] addr_t;
   // one extra bit for a sum before the buffer wrap
   typedef logic [`TERM_ADDR_BITS:0] wide_addr_t;
   typedef logic [`TERM_COL_BITS-1:0] col_t;
   typedef logic [`TERM_ROW_BITS-1:0] row_t;

   typedef enum logic [1:0] {
      dec_normal,
      dec_escape,
      dec_row,
      dec_col
   } decode_state_t;

   typedef enum logic [3:0] {
      op_print,
      op_backspace,
      op_tab,
      op_linefeed,
      op_return,
      op_up,
      op_down,
      op_right,
      op_left,
      op_home,
      op_goto,
      op_erase_line
   } cmd_op_t;

   // row is all ones when an Esc-Y row byte was out of range
   typedef struct packed {
      cmd_op_t op;
      char_t   ch;
      row_t    row;
      col_t    col;
   } term_cmd_t;

   typedef struct packed {
      col_t x;
      row_t y;
   } cursor_pos_t;

   // cells from first to last inclusive, wrapping at the buffer end
   typedef struct packed {
      char_t ch;
      addr_t first;
      addr_t last;
   } write_run_t;

   typedef struct packed {
      char_t ch;
      addr_t addr;
   } char_write_t;

endpackage

// File: hw/escape_decoder.sv
// ready is the plain inverse of busy; bytes 0x80 and up and unlisted control codes are dropped
`timescale 1ns/1ps
`include "term_params.svh"

module escape_decoder import term_pkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  char_t     data,
   input  logic      valid,
   input  logic      busy,
   output logic      ready,
   output term_cmd_t cmd,
   output logic      cmd_valid
);

   decode_state_t state;
   decode_state_t state_next;
   row_t          row_q;
   logic          accept;
   logic          row_in_range;
   logic          col_in_range;

   assign ready  = ~busy;
   assign accept = valid & ready;

   assign row_in_range = (data >= `TERM_POS_OFFSET) && (data < `TERM_POS_OFFSET + `TERM_ROWS);
   assign col_in_range = (data >= `TERM_POS_OFFSET) && (data < `TERM_POS_OFFSET + `TERM_COLS);

   always_comb begin
      state_next = state;
      cmd_valid  = 1'b0;
      cmd.op     = op_print;
      cmd.ch     = data;
      cmd.row    = row_q;
      cmd.col    = col_in_range ? col_t'(data - `TERM_POS_OFFSET) : col_t'(`TERM_COLS - 1);
      if (accept) begin
         case (state)
            dec_normal: begin
               cmd_valid = 1'b1;
               if (data >= `TERM_CH_SPACE && data < `TERM_CH_DEL) begin
                  cmd.op = op_print;
               end else begin
                  case (data)
                     `TERM_CH_BS:  cmd.op = op_backspace;
                     `TERM_CH_TAB: cmd.op = op_tab;
                     `TERM_CH_LF:  cmd.op = op_linefeed;
                     `TERM_CH_CR:  cmd.op = op_return;
                     `TERM_CH_ESC: begin
                        cmd_valid  = 1'b0;
                        state_next = dec_escape;
                     end
                     default:      cmd_valid = 1'b0;
                  endcase
               end
            end
            dec_escape: begin
               state_next = dec_normal;
               cmd_valid  = 1'b1;
               case (data)
                  "A": cmd.op = op_up;
                  "B": cmd.op = op_down;
                  "C": cmd.op = op_right;
                  "D": cmd.op = op_left;
                  "H": cmd.op = op_home;
                  "K": cmd.op = op_erase_line;
                  "Y": begin
                     cmd_valid  = 1'b0;
                     state_next = dec_row;
                  end
                  // a second escape keeps the sequence open
                  `TERM_CH_ESC: begin
                     cmd_valid  = 1'b0;
                     state_next = dec_escape;
                  end
                  default: cmd_valid = 1'b0;
               endcase
            end
            dec_row: state_next = dec_col;
            dec_col: begin
               cmd.op     = op_goto;
               cmd_valid  = 1'b1;
               state_next = dec_normal;
            end
            default: state_next = dec_normal;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= dec_normal;
      end else begin
         state <= state_next;
      end
   end

   // all ones marks a row that should be left unchanged
   always_ff @(posedge clk) begin
      if (accept && state == dec_row) begin
         row_q <= row_in_range ? row_t'(data - `TERM_POS_OFFSET) : '1;
      end
   end

endmodule

// File: hw/cursor_tracker.sv
// expects no command while tracker_busy is high; runs never exceed one row so no run wraps here
`timescale 1ns/1ps
`include "term_params.svh"

module cursor_tracker import term_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  term_cmd_t   cmd,
   input  logic        cmd_valid,
   output cursor_pos_t cursor,
   output logic        cursor_wen,
   output addr_t       first_char,
   output logic        first_char_wen,
   output write_run_t  run,
   output logic        run_valid,
   output logic        tracker_busy
);

   localparam col_t  last_col      = col_t'(`TERM_COLS - 1);
   localparam row_t  last_row      = row_t'(`TERM_ROWS - 1);
   localparam addr_t last_row_addr = addr_t'(`TERM_LAST_ROW);
   localparam addr_t row_step      = addr_t'(`TERM_COLS);

   addr_t      row_addr;
   addr_t      cell_addr;
   addr_t      goto_addr;
   logic       erase_hold;
   logic       goto_s1;
   logic       goto_s2;
   row_t       goto_row;
   col_t       goto_col;
   wide_addr_t goto_sum;

   function automatic addr_t row_below(addr_t a);
      return (a == last_row_addr) ? '0 : a + row_step;
   endfunction

   function automatic addr_t row_above(addr_t a);
      return (a == '0) ? last_row_addr : a - row_step;
   endfunction

   assign cell_addr    = row_addr + addr_t'(cursor.x);
   assign tracker_busy = goto_s1 | goto_s2 | erase_hold;

   // second Esc-Y stage, sum folded back into the buffer
   assign goto_addr = (goto_sum > wide_addr_t'(`TERM_LAST_ROW)) ?
                      addr_t'(goto_sum - wide_addr_t'(`TERM_BUF_SIZE)) : addr_t'(goto_sum);

   always_ff @(posedge clk) begin
      if (reset) begin
         cursor         <= '0;
         cursor_wen     <= 1'b0;
         first_char     <= '0;
         first_char_wen <= 1'b0;
         row_addr       <= '0;
         run_valid      <= 1'b0;
         erase_hold     <= 1'b0;
         goto_s1        <= 1'b0;
         goto_s2        <= 1'b0;
      end else begin
         cursor_wen     <= 1'b0;
         first_char_wen <= 1'b0;
         run_valid      <= 1'b0;
         erase_hold     <= 1'b0;
         goto_s1        <= 1'b0;
         goto_s2        <= goto_s1;
         if (goto_s2) begin
            cursor.x   <= goto_col;
            cursor.y   <= goto_row;
            row_addr   <= goto_addr;
            cursor_wen <= 1'b1;
         end
         if (cmd_valid) begin
            case (cmd.op)
               op_print: begin
                  run_valid <= 1'b1;
                  if (cursor.x != last_col) begin
                     cursor.x   <= cursor.x + col_t'(1);
                     cursor_wen <= 1'b1;
                  end
               end
               op_right: begin
                  if (cursor.x != last_col) begin
                     cursor.x   <= cursor.x + col_t'(1);
                     cursor_wen <= 1'b1;
                  end
               end
               op_backspace, op_left: begin
                  if (cursor.x != '0) begin
                     cursor.x   <= cursor.x - col_t'(1);
                     cursor_wen <= 1'b1;
                  end
               end
               op_tab: begin
                  // stops every 8 columns, then single steps near the right edge
                  if (cursor.x < col_t'(`TERM_TAB_LIMIT)) begin
                     cursor.x   <= (cursor.x + col_t'(8)) & ~col_t'(7);
                     cursor_wen <= 1'b1;
                  end else if (cursor.x != last_col) begin
                     cursor.x   <= cursor.x + col_t'(1);
                     cursor_wen <= 1'b1;
                  end
               end
               op_return: begin
                  if (cursor.x != '0) begin
                     cursor.x   <= '0;
                     cursor_wen <= 1'b1;
                  end
               end
               op_linefeed: begin
                  row_addr <= row_below(row_addr);
                  if (cursor.y == last_row) begin
                     // scroll, the old top row becomes the new bottom row
                     first_char     <= row_below(first_char);
                     first_char_wen <= 1'b1;
                     run_valid      <= 1'b1;
                     erase_hold     <= 1'b1;
                  end else begin
                     cursor.y   <= cursor.y + row_t'(1);
                     cursor_wen <= 1'b1;
                  end
               end
               op_down: begin
                  if (cursor.y != last_row) begin
                     cursor.y   <= cursor.y + row_t'(1);
                     row_addr   <= row_below(row_addr);
                     cursor_wen <= 1'b1;
                  end
               end
               op_up: begin
                  if (cursor.y != '0) begin
                     cursor.y   <= cursor.y - row_t'(1);
                     row_addr   <= row_above(row_addr);
                     cursor_wen <= 1'b1;
                  end
               end
               op_home: begin
                  cursor     <= '0;
                  row_addr   <= first_char;
                  cursor_wen <= (cursor != '0);
               end
               op_goto: goto_s1 <= 1'b1;
               op_erase_line: begin
                  run_valid  <= 1'b1;
                  erase_hold <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_valid) begin
         case (cmd.op)
            op_print:      run <= '{ch: cmd.ch, first: cell_addr, last: cell_addr};
            op_linefeed:   run <= '{ch: `TERM_CH_SPACE, first: first_char,
                                    last: first_char + addr_t'(last_col)};
            op_erase_line: run <= '{ch: `TERM_CH_SPACE, first: cell_addr,
                                    last: row_addr + addr_t'(last_col)};
            default: ;
         endcase
         if (cmd.op == op_goto) begin
            // an out-of-range row byte keeps the current row
            goto_row <= (cmd.row > last_row) ? cursor.y : cmd.row;
            goto_col <= cmd.col;
         end
      end
      if (goto_s1) begin
         goto_sum <= wide_addr_t'(first_char) +
                     wide_addr_t'(goto_row) * wide_addr_t'(`TERM_COLS);
      end
   end

endmodule

// File: hw/screen_writer.sv
// a new run must not arrive while writer_busy is high; addresses wrap at the buffer size
`timescale 1ns/1ps
`include "term_params.svh"

module screen_writer import term_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  write_run_t  run,
   input  logic        run_valid,
   output char_write_t char_wr,
   output logic        char_wen,
   output logic        writer_busy
);

   addr_t last_q;
   addr_t next_addr;
   logic  at_last;

   assign next_addr = (char_wr.addr == addr_t'(`TERM_BUF_SIZE - 1)) ?
                      '0 : char_wr.addr + addr_t'(1);
   assign at_last   = (char_wr.addr == last_q);

   always_ff @(posedge clk) begin
      if (reset) begin
         char_wen    <= 1'b0;
         writer_busy <= 1'b0;
      end else if (run_valid) begin
         char_wen    <= 1'b1;
         writer_busy <= (run.first != run.last);
      end else if (writer_busy) begin
         // stay busy through the cycle of the final write
         char_wen    <= ~at_last;
         writer_busy <= ~at_last;
      end else begin
         char_wen <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (run_valid) begin
         char_wr <= '{ch: run.ch, addr: run.first};
         last_q  <= run.last;
      end else if (writer_busy && !at_last) begin
         char_wr.addr <= next_addr;
      end
   end

endmodule

// File: hw/terminal_top.sv
// byte input takes one character per valid and ready cycle; all write ports are single-cycle pulses
`timescale 1ns/1ps

module terminal_top import term_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  char_t       data,
   input  logic        valid,
   output logic        ready,
   output char_write_t char_wr,
   output logic        char_wen,
   output cursor_pos_t cursor,
   output logic        cursor_wen,
   output addr_t       first_char,
   output logic        first_char_wen
);

   term_cmd_t  cmd;
   logic       cmd_valid;
   write_run_t run;
   logic       run_valid;
   logic       tracker_busy;
   logic       writer_busy;
   logic       busy;

   // input stalls while an address is computed or a run is written
   assign busy = tracker_busy | writer_busy;

   escape_decoder u_decoder (
      .clk       (clk),
      .reset     (reset),
      .data      (data),
      .valid     (valid),
      .busy      (busy),
      .ready     (ready),
      .cmd       (cmd),
      .cmd_valid (cmd_valid)
   );

   cursor_tracker u_tracker (
      .clk            (clk),
      .reset          (reset),
      .cmd            (cmd),
      .cmd_valid      (cmd_valid),
      .cursor         (cursor),
      .cursor_wen     (cursor_wen),
      .first_char     (first_char),
      .first_char_wen (first_char_wen),
      .run            (run),
      .run_valid      (run_valid),
      .tracker_busy   (tracker_busy)
   );

   screen_writer u_writer (
      .clk         (clk),
      .reset       (reset),
      .run         (run),
      .run_valid   (run_valid),
      .char_wr     (char_wr),
      .char_wen    (char_wen),
      .writer_busy (writer_busy)
   );

endmodule

// File: verif/tb_stimulus.svh
// step table for tb_terminal; expects step_t and the steps queue declared before the include
`ifndef TB_STIMULUS_SVH
`define TB_STIMULUS_SVH

// fields of one step are input byte, cursor x and y, first_char, checked address and its char
// a checked address of -1 means no cell is checked
task automatic add_step(input int b, input int x, input int y, input int first,
                        input int addr, input int ch);
   step_t s;
   s.data  = char_t'(b);
   s.x     = col_t'(x);
   s.y     = row_t'(y);
   s.first = addr_t'(first);
   s.chk   = (addr >= 0);
   s.addr  = (addr >= 0) ? addr_t'(addr) : '0;
   s.ch    = char_t'(ch);
   steps.push_back(s);
endtask

// Esc-Y sequence where the cursor only moves on the column byte
task automatic add_goto(input int row_b, input int col_b, input int x, input int y,
                        input int new_x, input int new_y, input int first);
   add_step(`TERM_CH_ESC, x, y, first, -1, 0);
   add_step("Y", x, y, first, -1, 0);
   add_step(row_b, x, y, first, -1, 0);
   add_step(col_b, new_x, new_y, first, -1, 0);
endtask

task automatic build_table();
   int k;
   // text and control codes
   add_step("H", 1, 0, 0, 0, "H");
   add_step("i", 2, 0, 0, 1, "i");
   add_step(`TERM_CH_BS, 1, 0, 0, -1, 0);
   add_step("o", 2, 0, 0, 1, "o");
   add_step(`TERM_CH_TAB, 8, 0, 0, -1, 0);
   add_step(`TERM_CH_TAB, 16, 0, 0, -1, 0);
   add_step(`TERM_CH_CR, 0, 0, 0, -1, 0);
   add_step(`TERM_CH_LF, 0, 1, 0, -1, 0);
   add_step("x", 1, 1, 0, 80, "x");
   // tab near the right edge, then overwrite of column 79
   add_goto(8'h20, 8'h66, 1, 1, 70, 0, 0);
   add_step(`TERM_CH_TAB, 72, 0, 0, -1, 0);
   add_step(`TERM_CH_TAB, 73, 0, 0, -1, 0);
   add_goto(8'h20, 8'h6E, 73, 0, 78, 0, 0);
   add_step("a", 79, 0, 0, 78, "a");
   add_step("b", 79, 0, 0, 79, "b");
   add_step("c", 79, 0, 0, 79, "c");
   // single steps with clamping
   // a clamped Esc-C must not print over column 79
   add_step(`TERM_CH_ESC, 79, 0, 0, -1, 0);
   add_step("C", 79, 0, 0, 79, "c");
   add_step(`TERM_CH_ESC, 79, 0, 0, -1, 0);
   add_step("D", 78, 0, 0, -1, 0);
   add_step(`TERM_CH_ESC, 78, 0, 0, -1, 0);
   add_step("A", 78, 0, 0, -1, 0);
   add_step(`TERM_CH_ESC, 78, 0, 0, -1, 0);
   add_step("B", 78, 1, 0, -1, 0);
   add_step(`TERM_CH_ESC, 78, 1, 0, -1, 0);
   add_step("H", 0, 0, 0, -1, 0);
   // doubled escape, then an unknown letter
   // the letter after the doubled escape moves the cursor and leaves cell 0 alone
   add_step(`TERM_CH_ESC, 0, 0, 0, -1, 0);
   add_step(`TERM_CH_ESC, 0, 0, 0, -1, 0);
   add_step("C", 1, 0, 0, 0, "H");
   add_step(`TERM_CH_ESC, 1, 0, 0, -1, 0);
   add_step("Z", 1, 0, 0, -1, 0);
   add_step("q", 2, 0, 0, 1, "q");
   // out-of-range row keeps the row and out-of-range column gives 79
   add_goto(8'h3E, 8'h25, 2, 0, 5, 0, 0);
   add_goto(8'h2A, 8'h7E, 5, 0, 79, 10, 0);
   add_step("e", 79, 10, 0, 879, "e");
   // erase to end of line from column 2 of row 2
   add_goto(8'h22, 8'h20, 79, 10, 0, 2, 0);
   add_step("P", 1, 2, 0, 160, "P");
   add_step("Q", 2, 2, 0, 161, "Q");
   add_step("R", 3, 2, 0, 162, "R");
   add_step(`TERM_CH_BS, 2, 2, 0, -1, 0);
   add_step(`TERM_CH_ESC, 2, 2, 0, -1, 0);
   add_step("K", 2, 2, 0, 162, " ");
   add_step(8'h00, 2, 2, 0, 161, "Q");
   add_step(8'h00, 2, 2, 0, 239, " ");
   // one-cell erase at the last column
   add_goto(8'h23, 8'h6F, 2, 2, 79, 3, 0);
   add_step("k", 79, 3, 0, 319, "k");
   add_step(`TERM_CH_ESC, 79, 3, 0, -1, 0);
   add_step("K", 79, 3, 0, 319, " ");
   // first scroll from the bottom row
   add_goto(8'h37, 8'h20, 79, 3, 0, 23, 0);
   add_step("Z", 1, 23, 0, 1840, "Z");
   add_step(`TERM_CH_LF, 1, 23, 80, 79, " ");
   add_step("W", 2, 23, 80, 1, "W");
   // Esc-Y on a scrolled screen with and without the wrap
   add_goto(8'h37, 8'h23, 2, 23, 3, 23, 80);
   add_step("V", 4, 23, 80, 3, "V");
   add_goto(8'h21, 8'h20, 4, 23, 0, 1, 80);
   add_step("U", 1, 1, 80, 160, "U");
   add_goto(8'h37, 8'h20, 1, 1, 0, 23, 80);
   // remaining scrolls bring first_char round to 0
   // the checked cell of each erased row moves one column per scroll
   for (k = 2; k <= `TERM_ROWS; k++) begin
      add_step(`TERM_CH_LF, 0, 23, (k * `TERM_COLS) % `TERM_BUF_SIZE,
               (k - 1) * `TERM_COLS + k - 2, " ");
   end
   add_step("T", 1, 23, 0, 1840, "T");
endtask

`endif

// File: verif/tb_terminal.sv
// screen model starts with a non-printable fill so unwritten cells never match a printed char
`timescale 1ns/1ps
`include "term_params.svh"

module tb_terminal import term_pkg::*; ();

   typedef struct packed {
      char_t data;
      col_t  x;
      row_t  y;
      addr_t first;
      logic  chk;
      addr_t addr;
      char_t ch;
   } step_t;

   localparam int wait_limit = 200;

   logic        clk;
   logic        reset;
   char_t       data;
   logic        valid;
   logic        ready;
   char_write_t char_wr;
   logic        char_wen;
   cursor_pos_t cursor;
   logic        cursor_wen;
   addr_t       first_char;
   logic        first_char_wen;

   step_t       steps[$];
   char_t       screen [0:`TERM_BUF_SIZE-1];
   cursor_pos_t seen_cursor;
   addr_t       seen_first;

   `include "tb_stimulus.svh"

   terminal_top uut (
      .clk            (clk),
      .reset          (reset),
      .data           (data),
      .valid          (valid),
      .ready          (ready),
      .char_wr        (char_wr),
      .char_wen       (char_wen),
      .cursor         (cursor),
      .cursor_wen     (cursor_wen),
      .first_char     (first_char),
      .first_char_wen (first_char_wen)
   );

   always #50 clk = ~clk;

   // shadow of the screen buffer and of the last cursor and first row written
   always @(posedge clk) begin
      if (char_wen) begin
         screen[char_wr.addr] <= char_wr.ch;
      end
      if (cursor_wen) begin
         seen_cursor <= cursor;
      end
      if (first_char_wen) begin
         seen_first <= first_char;
      end
   end

   task automatic stop_run(input string reason);
      if (reason.len() > 0) begin
         $display("%s", reason);
      end
      $display("** FAIL **");
      $fatal(1, "run stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want) begin
         $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, want);
         stop_run("");
      end
   endtask

   // called at a falling edge, returns at the falling edge after the accept
   task automatic send_byte(input char_t b);
      int count;
      count = 0;
      data  = b;
      valid = 1'b1;
      while (!ready && count < wait_limit) begin
         @(negedge clk);
         count++;
      end
      if (!ready) begin
         stop_run($sformatf("Timeout: byte 0x%0h was never accepted", b));
      end else begin
         @(posedge clk);
         @(negedge clk);
         valid = 1'b0;
      end
   endtask

   task automatic wait_ready();
      int count;
      count = 0;
      while (!ready && count < wait_limit) begin
         @(negedge clk);
         count++;
      end
      if (!ready) begin
         stop_run("Timeout: ready stayed low after a byte was accepted");
      end
   endtask

   initial begin
      int i;
      clk         = 1'b0;
      reset       = 1'b1;
      data        = '0;
      valid       = 1'b0;
      seen_cursor = '0;
      seen_first  = '0;
      for (i = 0; i < `TERM_BUF_SIZE; i++) begin
         screen[i] = {1'b1, i[6:0] ^ {3'b000, i[10:7]}};
      end
      build_table();
      repeat (16) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check_value("ready", ready, 1);
      check_value("char_wen", char_wen, 0);
      check_value("cursor_wen", cursor_wen, 0);
      check_value("first_char_wen", first_char_wen, 0);
      check_value("cursor", cursor, 0);
      check_value("first_char", first_char, 0);
      for (i = 0; i < steps.size(); i++) begin
         send_byte(steps[i].data);
         wait_ready();
         // print writes and the Esc-Y cursor write land up to two edges after ready
         repeat (2) @(negedge clk);
         check_value("cursor.x", seen_cursor.x, steps[i].x);
         check_value("cursor.y", seen_cursor.y, steps[i].y);
         check_value("first_char", seen_first, steps[i].first);
         if (steps[i].chk) begin
            check_value($sformatf("char at 0x%0h", steps[i].addr),
                        screen[steps[i].addr], steps[i].ch);
         end
      end
      $display("** PASS **");
      $finish;
   end

endmodule

// File: compile.f
+incdir+hw
+incdir+verif
hw/term_pkg.sv
hw/escape_decoder.sv
hw/cursor_tracker.sv
hw/screen_writer.sv
hw/terminal_top.sv
verif/tb_terminal.sv

// File: Bender.yml
package:
  name: vt52_terminal

sources:
  - include_dirs:
      - hw
    files:
      - hw/term_pkg.sv
      - hw/escape_decoder.sv
      - hw/cursor_tracker.sv
      - hw/screen_writer.sv
      - hw/terminal_top.sv

  - target: test
    include_dirs:
      - hw
      - verif
    files:
      - verif/tb_terminal.sv
